/* hw/cache_array_if.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

interface cache_array_if import cache_pkg::*; ();

    // lookup, driven by the controller
    logic [`CACHE_INDEX_W-1:0] index;
    logic [`CACHE_TAG_W-1:0]   lookup_tag;
    // write port, takes effect on the next edge
    logic                      tag_we;
    logic                      data_we;
    logic                      wr_way;
    logic [`CACHE_TAG_W-1:0]   wr_tag;
    logic                      wr_dirty;
    line_t                     wr_line;

    // lookup result, combinational in the array
    logic                      hit;
    logic                      hit_way;
    // hit line, or victim line on a miss
    line_t                     rd_line;
    logic                      victim_way;
    logic [`CACHE_TAG_W-1:0]   victim_tag;
    logic                      victim_dirty;

    modport ctrl (
        output index, lookup_tag, tag_we, data_we, wr_way, wr_tag, wr_dirty, wr_line,
        input  hit, hit_way, rd_line, victim_way, victim_tag, victim_dirty
    );

    modport array (
        input  index, lookup_tag, tag_we, data_we, wr_way, wr_tag, wr_dirty, wr_line,
        output hit, hit_way, rd_line, victim_way, victim_tag, victim_dirty
    );

endinterface

`default_nettype wire

/* hw/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// geometry of the data cache
// two ways only, the array logic is written for exactly two
`define CACHE_WAYS 2
`define CACHE_SETS 16
`define CACHE_INDEX_W 4
// 32-bit words per line
`define CACHE_WORDS 4
// 32 - index - word select - byte offset
`define CACHE_TAG_W 24

`endif

/* hw/cache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl import cache_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    // cpu request
    input  logic        req_valid_i,
    input  logic        req_we_i,
    input  cache_addr_u req_addr_i,
    input  logic [31:0] req_wdata_i,
    // cpu response
    output logic        resp_valid_o,
    output logic        resp_hit_o,
    output logic [31:0] resp_rdata_o,
    output logic        busy_o,
    // memory request
    output logic        mem_req_valid_o,
    output logic        mem_req_we_o,
    output logic [31:0] mem_req_addr_o,
    output line_t       mem_req_wdata_o,
    // memory response
    input  logic        mem_resp_valid_i,
    input  line_t       mem_resp_rdata_i,
    // tag and data arrays
    cache_array_if.ctrl arr,
    // recency update
    output logic        lru_touch_o,
    output logic        lru_way_o
);

    ctrl_state_e state_q, state_d;

    // latched cpu request
    cache_addr_u addr_q;
    logic        we_q;
    logic [31:0] wdata_q;
    // still in the first compare of this request
    logic        first_q;

    // line addresses for memory
    cache_addr_u wb_addr;
    cache_addr_u fill_addr;
    // hit line with the write word merged in
    line_t       merged_line;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            first_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && req_valid_i) begin
                first_q <= 1'b1;
            end else if (state_q == COMPARE && !arr.hit) begin
                // the later compare after the fill is no longer first
                first_q <= 1'b0;
            end
        end
    end

    // request payload, captured on the strobe
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && req_valid_i) begin
            addr_q  <= req_addr_i;
            we_q    <= req_we_i;
            wdata_q <= req_wdata_i;
        end
    end

    always_comb begin
        // victim line lives at its own tag with our index
        wb_addr.raw     = '0;
        wb_addr.f.tag   = arr.victim_tag;
        wb_addr.f.index = addr_q.f.index;
        // missing line, word and byte cleared
        fill_addr            = addr_q;
        fill_addr.f.word     = 2'b00;
        fill_addr.f.byte_off = 2'b00;
        // read-modify-write of one word
        merged_line                = arr.rd_line;
        merged_line[addr_q.f.word] = wdata_q;
    end

    // lookup always uses the latched request
    assign arr.index      = addr_q.f.index;
    assign arr.lookup_tag = addr_q.f.tag;

    always_comb begin
        state_d         = state_q;
        resp_valid_o    = 1'b0;
        mem_req_valid_o = 1'b0;
        mem_req_we_o    = 1'b0;
        mem_req_addr_o  = fill_addr.raw;
        // default write targets the hit way with the merged word
        arr.tag_we      = 1'b0;
        arr.data_we     = 1'b0;
        arr.wr_way      = arr.hit_way;
        arr.wr_tag      = addr_q.f.tag;
        arr.wr_dirty    = 1'b0;
        arr.wr_line     = merged_line;

        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    state_d = COMPARE;
                end
            end
            COMPARE: begin
                if (arr.hit) begin
                    resp_valid_o = 1'b1;
                    // write hit, same tag, line now dirty
                    if (we_q) begin
                        arr.tag_we   = 1'b1;
                        arr.data_we  = 1'b1;
                        arr.wr_dirty = 1'b1;
                    end
                    state_d = IDLE;
                end else begin
                    mem_req_valid_o = 1'b1;
                    if (arr.victim_dirty) begin
                        // push the victim out first
                        mem_req_we_o   = 1'b1;
                        mem_req_addr_o = wb_addr.raw;
                        state_d        = WRITE_BACK;
                    end else begin
                        state_d = ALLOCATE;
                    end
                end
            end
            WRITE_BACK: begin
                // write acked, ask for the missing line
                if (mem_resp_valid_i) begin
                    mem_req_valid_o = 1'b1;
                    state_d         = ALLOCATE;
                end
            end
            ALLOCATE: begin
                arr.wr_way  = arr.victim_way;
                arr.wr_line = mem_resp_rdata_i;
                // fill with a clean tag, then compare again
                if (mem_resp_valid_i) begin
                    arr.tag_we  = 1'b1;
                    arr.data_we = 1'b1;
                    state_d     = COMPARE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // victim line is what rd_line shows on a miss
    assign mem_req_wdata_o = arr.rd_line;
    assign resp_rdata_o    = arr.rd_line[addr_q.f.word];
    assign resp_hit_o      = resp_valid_o & first_q;
    assign busy_o          = (state_q != IDLE);

    // touch the accessed way on every response
    assign lru_touch_o = resp_valid_o;
    assign lru_way_o   = arr.hit_way;

endmodule

`default_nettype wire

/* hw/cache_lru.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module cache_lru (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic [`CACHE_INDEX_W-1:0] index_i,
    // accessed way, one strobe per response
    input  logic                      touch_i,
    input  logic                      touch_way_i,
    output logic                      lru_way_o
);

    // one bit per set, names the older way
    logic [`CACHE_SETS-1:0] lru_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lru_q <= '0;
        end else if (touch_i) begin
            // the other way becomes least recent
            lru_q[index_i] <= ~touch_way_i;
        end
    end

    assign lru_way_o = lru_q[index_i];

endmodule

`default_nettype wire

/* hw/cache_pkg.sv */
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

    // request address split into its cache fields
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]   tag;
        logic [`CACHE_INDEX_W-1:0] index;
        logic [1:0]                word;
        logic [1:0]                byte_off;
    } addr_fields_t;

    // same 32 bits seen raw or as fields
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } cache_addr_u;

    // one cache line, word 0 in the low bits
    typedef logic [`CACHE_WORDS-1:0][31:0] line_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        WRITE_BACK,
        ALLOCATE
    } ctrl_state_e;

endpackage

`default_nettype wire

/* hw/cache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_top import cache_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    // cpu port
    input  logic        req_valid_i,
    input  logic        req_we_i,
    input  cache_addr_u req_addr_i,
    input  logic [31:0] req_wdata_i,
    output logic        resp_valid_o,
    output logic        resp_hit_o,
    output logic [31:0] resp_rdata_o,
    output logic        busy_o,
    // memory port, line wide
    output logic        mem_req_valid_o,
    output logic        mem_req_we_o,
    output logic [31:0] mem_req_addr_o,
    output line_t       mem_req_wdata_o,
    input  logic        mem_resp_valid_i,
    input  line_t       mem_resp_rdata_i
);

    // controller to array
    cache_array_if arr_if ();

    // recency tracking
    logic lru_touch;
    logic lru_touch_way;
    logic lru_way;

    cache_ctrl cache_ctrl_inst (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_valid_i      (req_valid_i),
        .req_we_i         (req_we_i),
        .req_addr_i       (req_addr_i),
        .req_wdata_i      (req_wdata_i),
        .resp_valid_o     (resp_valid_o),
        .resp_hit_o       (resp_hit_o),
        .resp_rdata_o     (resp_rdata_o),
        .busy_o           (busy_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_we_o     (mem_req_we_o),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_wdata_o  (mem_req_wdata_o),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_rdata_i (mem_resp_rdata_i),
        .arr              (arr_if.ctrl),
        .lru_touch_o      (lru_touch),
        .lru_way_o        (lru_touch_way)
    );

    cache_ways cache_ways_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .arr       (arr_if.array),
        .lru_way_i (lru_way)
    );

    // same set index as the array lookup
    cache_lru cache_lru_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .index_i     (arr_if.index),
        .touch_i     (lru_touch),
        .touch_way_i (lru_touch_way),
        .lru_way_o   (lru_way)
    );

endmodule

`default_nettype wire

/* hw/cache_ways.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module cache_ways import cache_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_ni,
    cache_array_if.array  arr,
    // least recently used way of the indexed set
    input  logic          lru_way_i
);

    // state bits per way and set
    logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] valid_q;
    logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] dirty_q;
    // tag and line storage
    logic [`CACHE_TAG_W-1:0] tag_q  [`CACHE_WAYS][`CACHE_SETS];
    line_t                   data_q [`CACHE_WAYS][`CACHE_SETS];

    logic [`CACHE_WAYS-1:0] way_match;
    logic [`CACHE_WAYS-1:0] set_valid;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (arr.tag_we) begin
            // any tag write leaves the line valid
            valid_q[arr.wr_way][arr.index] <= 1'b1;
            dirty_q[arr.wr_way][arr.index] <= arr.wr_dirty;
        end
    end

    always_ff @(posedge clk_i) begin
        if (arr.tag_we) begin
            tag_q[arr.wr_way][arr.index] <= arr.wr_tag;
        end
        if (arr.data_we) begin
            data_q[arr.wr_way][arr.index] <= arr.wr_line;
        end
    end

    // tag compare on both ways
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            set_valid[w] = valid_q[w][arr.index];
            way_match[w] = set_valid[w] && (tag_q[w][arr.index] == arr.lookup_tag);
        end
    end

    assign arr.hit     = |way_match;
    assign arr.hit_way = way_match[1];

    // victim: empty way first, way 0 before way 1, else lru
    always_comb begin
        if (!set_valid[0]) begin
            arr.victim_way = 1'b0;
        end else if (!set_valid[1]) begin
            arr.victim_way = 1'b1;
        end else begin
            arr.victim_way = lru_way_i;
        end
    end

    assign arr.victim_tag   = tag_q[arr.victim_way][arr.index];
    // dirty only counts on a valid line
    assign arr.victim_dirty = set_valid[arr.victim_way] & dirty_q[arr.victim_way][arr.index];

    // hit line, or victim line for write back
    assign arr.rd_line = arr.hit ? data_q[arr.hit_way][arr.index]
                                 : data_q[arr.victim_way][arr.index];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --Mdir obj_dir \
    --top-module cache_tb -f src.f

out="$(./obj_dir/Vcache_tb || true)"
echo "$out"
echo "$out" | grep -qx "STATUS: PASS"

/* src.f */
+incdir+hw
hw/cache_pkg.sv
hw/cache_array_if.sv
hw/cache_lru.sv
hw/cache_ways.sv
hw/cache_ctrl.sv
hw/cache_top.sv
test/cache_chk.sv
test/cache_tb.sv

/* test/cache_cases.txt */
# op (R read, W write)  address (hex)  write data (hex, ignored on reads)
# addresses stay below 0x1000, set index is address bits 7:4
R 00000000 00000000
R 00000004 00000000
W 00000008 aaaa5555
R 00000008 00000000
R 0000000c 00000000
R 00000104 00000000
R 00000208 00000000
R 00000100 00000000
R 00000000 00000000
R 00000008 00000000
R 00000200 00000000
W 0000030c 12345678
R 00000204 00000000
R 0000030c 00000000
R 00000404 00000000
R 00000500 00000000
W 00000050 deadbeef
W 00000054 cafef00d
R 00000050 00000000
R 0000015c 00000000
R 0000025c 00000000
R 00000054 00000000
R 0000030c 00000000
R 00000ff0 00000000

/* test/cache_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_chk import cache_pkg::*; (
    input logic        clk_i,
    input logic        rst_ni,
    input logic        req_valid_i,
    input logic        busy_o,
    input logic        resp_valid_o,
    input logic        mem_req_valid_o,
    input logic        mem_resp_valid_i,
    input ctrl_state_e state_i
);

    // a memory request is waiting for its response
    logic mem_open_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_open_q <= 1'b0;
        end else if (mem_resp_valid_i) begin
            // the read after a write back may start in the ack cycle
            mem_open_q <= mem_req_valid_o;
        end else if (mem_req_valid_o) begin
            mem_open_q <= 1'b1;
        end
    end

    resp_in_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        resp_valid_o |-> busy_o)
        else $error("resp_valid_o seen while busy_o is low");

    one_mem_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o |-> (!mem_open_q || mem_resp_valid_i))
        else $error("second memory request before the response");

    no_req_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i |-> !busy_o)
        else $error("cpu request arrived while busy_o is high");

    // first clock with reset released
    reset_quiet: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> (!resp_valid_o && !mem_req_valid_o && !busy_o && state_i == IDLE))
        else $error("outputs not idle after reset release");

endmodule

bind cache_ctrl cache_chk cache_chk_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_valid_i      (req_valid_i),
    .busy_o           (busy_o),
    .resp_valid_o     (resp_valid_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_resp_valid_i (mem_resp_valid_i),
    .state_i          (state_q)
);

`default_nettype wire

/* test/cache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module cache_tb import cache_pkg::*; ();

    logic        clk_i;
    logic        rst_ni;
    logic        req_valid_i;
    logic        req_we_i;
    cache_addr_u req_addr_i;
    logic [31:0] req_wdata_i;
    logic        resp_valid_o;
    logic        resp_hit_o;
    logic [31:0] resp_rdata_o;
    logic        busy_o;
    logic        mem_req_valid_o;
    logic        mem_req_we_o;
    logic [31:0] mem_req_addr_o;
    line_t       mem_req_wdata_o;
    logic        mem_resp_valid_i;
    line_t       mem_resp_rdata_i;

    // backing memory and the cpu view of it, 4 KiB each
    logic [31:0] mem     [1024];
    logic [31:0] ref_mem [1024];
    // reference cache state per way and set
    logic                    m_valid [2][`CACHE_SETS];
    logic                    m_dirty [2][`CACHE_SETS];
    logic [`CACHE_TAG_W-1:0] m_tag   [2][`CACHE_SETS];
    logic                    m_lru   [`CACHE_SETS];

    // memory traffic the model expects for the current access
    bit          wb_pending;
    logic [31:0] wb_addr_exp;
    line_t       wb_line_exp;
    bit          fill_pending;
    logic [31:0] fill_addr_exp;
    // memory model state
    bit          mem_busy;
    int          mem_wait;
    line_t       mem_rdata;
    logic [31:0] rng;
    int          value_errors;
    int          other_errors;

    cache_top cache_top_inst (.*);

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // four words of one line, from the backing or the cpu view
    function automatic line_t gather_line(input logic [7:0] line_idx, input bit from_ref);
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k[1:0]] = from_ref ? ref_mem[{line_idx, k[1:0]}] : mem[{line_idx, k[1:0]}];
        end
        return l;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_hit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("CHECK FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            value_errors++;
            $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // reference model: hit, victim choice, write back, fill and lru update
    task automatic predict(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                           output logic hit, output logic [31:0] rdata);
        cache_addr_u a;
        logic [3:0]  set;
        logic        way;
        a.raw = addr;
        set   = a.f.index;
        hit   = 1'b1;
        way   = 1'b0;
        if (m_valid[0][set] && m_tag[0][set] == a.f.tag) begin
            way = 1'b0;
        end else if (m_valid[1][set] && m_tag[1][set] == a.f.tag) begin
            way = 1'b1;
        end else begin
            hit = 1'b0;
            // empty way first, else the older one
            if (!m_valid[0][set]) begin
                way = 1'b0;
            end else if (!m_valid[1][set]) begin
                way = 1'b1;
            end else begin
                way = m_lru[set];
            end
            if (m_valid[way][set] && m_dirty[way][set]) begin
                wb_addr_exp = {m_tag[way][set], set, 4'h0};
                wb_line_exp = gather_line(wb_addr_exp[11:4], 1'b1);
                wb_pending  = 1'b1;
            end
            fill_addr_exp = {addr[31:4], 4'h0};
            fill_pending  = 1'b1;
            m_valid[way][set] = 1'b1;
            m_dirty[way][set] = 1'b0;
            m_tag[way][set]   = a.f.tag;
        end
        rdata = ref_mem[addr[11:2]];
        if (we) begin
            ref_mem[addr[11:2]] = wdata;
            m_dirty[way][set]   = 1'b1;
        end
        m_lru[set] = ~way;
    endtask

    task automatic run_access(input logic [7:0] op, input logic [31:0] addr,
                              input logic [31:0] wdata, output bit ok);
        logic        exp_hit;
        logic [31:0] exp_rdata;
        int          cycles;
        ok = 1'b1;
        predict(op == "W", addr, wdata, exp_hit, exp_rdata);
        @(posedge clk_i);
        #1;
        req_valid_i    = 1'b1;
        req_we_i       = (op == "W");
        req_addr_i.raw = addr;
        req_wdata_i    = wdata;
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!resp_valid_o && cycles < 200);
        if (!resp_valid_o) begin
            other_errors++;
            $display("timeout: no response within 200 cycles for access to %h", addr);
            ok = 1'b0;
        end else begin
            check_hit("resp_hit_o", exp_hit, resp_hit_o);
            check_hit("busy_o", 1'b1, busy_o);
            if (op != "W") begin
                check_word("resp_rdata_o", exp_rdata, resp_rdata_o);
            end
            if (exp_hit && cycles != 1) begin
                other_errors++;
                $display("hit on %h answered after %0d cycles instead of 1", addr, cycles);
            end
            if (wb_pending || fill_pending) begin
                other_errors++;
                $display("expected memory request for access to %h never came", addr);
            end
        end
    endtask

    // memory model, samples at the falling edge and answers 1 to 4 cycles later
    always begin
        @(negedge clk_i);
        if (mem_req_valid_o) begin
            if (mem_busy) begin
                other_errors++;
                $display("memory request at %h while another one is open", mem_req_addr_o);
            end
            if (mem_req_we_o) begin
                if (!wb_pending) begin
                    other_errors++;
                    $display("unexpected write back of line %h", mem_req_addr_o);
                end else begin
                    check_addr("mem_req_addr_o", wb_addr_exp, mem_req_addr_o);
                    check_line("mem_req_wdata_o", wb_line_exp, mem_req_wdata_o);
                end
                wb_pending = 1'b0;
                for (int k = 0; k < 4; k++) begin
                    mem[{mem_req_addr_o[11:4], k[1:0]}] = mem_req_wdata_o[k[1:0]];
                end
            end else begin
                if (!fill_pending) begin
                    other_errors++;
                    $display("unexpected line read at %h", mem_req_addr_o);
                end else begin
                    check_addr("mem_req_addr_o", fill_addr_exp, mem_req_addr_o);
                end
                fill_pending = 1'b0;
                mem_rdata    = gather_line(mem_req_addr_o[11:4], 1'b0);
            end
            rng      = xorshift32(rng);
            mem_wait = 1 + int'(rng[1:0]);
            mem_busy = 1'b1;
        end
        @(posedge clk_i);
        #1;
        mem_resp_valid_i = 1'b0;
        if (mem_busy) begin
            if (mem_wait == 1) begin
                mem_resp_valid_i = 1'b1;
                mem_resp_rdata_i = mem_rdata;
                mem_busy         = 1'b0;
            end else begin
                mem_wait--;
            end
        end
    end

    initial begin : stimulus
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        bit          ok;
        bit          done;
        clk_i            = 1'b0;
        rst_ni           = 1'b0;
        req_valid_i      = 1'b0;
        req_we_i         = 1'b0;
        req_addr_i       = '0;
        req_wdata_i      = '0;
        mem_resp_valid_i = 1'b0;
        mem_resp_rdata_i = '0;
        rng              = 32'h5d164a1b;
        for (int i = 0; i < 1024; i++) begin
            rng             = xorshift32(rng);
            mem[i[9:0]]     = rng;
            ref_mem[i[9:0]] = rng;
        end
        for (int s = 0; s < `CACHE_SETS; s++) begin
            m_valid[0][s[3:0]] = 1'b0;
            m_valid[1][s[3:0]] = 1'b0;
            m_dirty[0][s[3:0]] = 1'b0;
            m_dirty[1][s[3:0]] = 1'b0;
            m_lru[s[3:0]]      = 1'b0;
        end
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_hit("busy_o", 1'b0, busy_o);
        check_hit("resp_valid_o", 1'b0, resp_valid_o);
        check_hit("mem_req_valid_o", 1'b0, mem_req_valid_o);

        fd   = $fopen("test/cache_cases.txt", "r");
        done = (fd == 0);
        if (fd == 0) begin
            other_errors++;
            $display("could not open test/cache_cases.txt");
        end
        while (!done) begin
            n = $fgets(line, fd);
            if (n == 0) begin
                done = 1'b1;
            end else if (line.getc(0) != "#" && $sscanf(line, "%c %h %h", op, addr, wdata) == 3) begin
                if (addr[31:12] != 20'd0) begin
                    other_errors++;
                    $display("case address %h lies outside the modeled memory", addr);
                end else begin
                    run_access(op, addr, wdata, ok);
                    done = !ok;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors != 0 || other_errors != 0) begin
            $display("STATUS: FAIL");
        end else begin
            $display("STATUS: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire
